// File: common/csam_pkg.sv
package csam_pkg;

        localparam int x_w = 16;        // multiplicand width.
        localparam int y_w = 12;        // multiplier width.
        localparam int p_w = x_w + y_w;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stage payloads
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        typedef struct packed {
                logic [x_w-1:0] x;
                logic [y_w-1:0] y;
        } operands_t;

        // row r holds x & y[r] at weight 2**r, sign terms already inverted.
        typedef struct packed {
                logic [y_w-1:0][x_w-1:0] row;
        } pp_matrix_t;

        typedef struct packed {
                logic [x_w-1:0] sum;            // sum[i] weighs 2**(y_w-1+i).
                logic [x_w-2:0] carry;          // carry[i] weighs 2**(y_w+i).
                logic [y_w-1:0] low_bits;       // finished product bits.
        } csa_state_t;

        typedef logic signed [p_w-1:0] product_t;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // adder cells
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        // both cells return the carry in bit 1 and the sum in bit 0.
        function automatic logic [1:0] full_add(input logic a, input logic b, input logic c);
                return {(a & b) | (a & c) | (b & c), a ^ b ^ c};
        endfunction

        function automatic logic [1:0] half_add(input logic a, input logic b);
                return {a & b, a ^ b};
        endfunction

endpackage

// File: csam/csam_partial_products.sv
`timescale 1ns/10ps

module csam_partial_products import csam_pkg::*; (
        input  logic       clk,
        input  logic       rst,
        input  logic       in_valid,
        output logic       in_ready,
        input  operands_t  in_data,
        output logic       pp_valid,
        input  logic       pp_ready,
        output pp_matrix_t pp_data
);

        pp_matrix_t pp_next;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Baugh-Wooley matrix
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        // a term is negative when exactly one of its two bits is a sign bit.
        // Those terms are inverted, and the array and final adder add the constant back.
        always_comb begin
                for (int r = 0; r < y_w; r++) begin
                        for (int c = 0; c < x_w; c++) begin
                                pp_next.row[r][c] = in_data.x[c] & in_data.y[r];
                                if ((r == y_w - 1) != (c == x_w - 1)) begin
                                        pp_next.row[r][c] = ~pp_next.row[r][c];
                                end
                        end
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stage register
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign in_ready = !pp_valid || pp_ready;        // empty, or the array takes ours now.

        always_ff @(posedge clk) begin
                if (rst) begin
                        pp_valid <= 1'b0;
                end else if (in_ready) begin
                        pp_valid <= in_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                        pp_data <= pp_next;
                end
        end

        // a stalled matrix waits unchanged for the array.
        a_pp_hold: assert property (@(posedge clk) disable iff (rst)
                pp_valid && !pp_ready |=> pp_valid && $stable(pp_data));

endmodule

// File: csam/csam_array.sv
`timescale 1ns/10ps

module csam_array import csam_pkg::*; (
        input  logic       clk,
        input  logic       rst,
        input  logic       pp_valid,
        output logic       pp_ready,
        input  pp_matrix_t pp_data,
        output logic       csa_valid,
        input  logic       csa_ready,
        output csa_state_t csa_data
);

        // the inverted terms leave a constant of 2**27 + 2**15 + 2**11 to add back.
        // The two low ones enter here, on the free inputs of the first row.
        // The result stage adds 2**27 by inverting its last carry.
        localparam logic [x_w-1:0] bw_corr = (x_w'(1) << (x_w - 1)) | (x_w'(1) << (y_w - 1));

        logic [y_w-1:0][x_w-1:0] pp;
        logic [x_w-1:0]          sum_row [1:y_w-1];
        logic [x_w-2:0]          cry_row [1:y_w-1];
        logic [y_w-1:0]          low_bits;
        csa_state_t              csa_next;

        assign pp = pp_data.row;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // carry-save rows
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        // row k bit j weighs 2**(k+j). Its carry goes one column left, into row k+1.
        for (genvar k = 1; k < y_w; k++) begin : g_row
                assign sum_row[k][x_w-1] = pp[k][x_w-1];        // top term has nothing to add.
                assign low_bits[k] = sum_row[k][0];             // this column is finished.

                for (genvar j = 0; j < x_w - 1; j++) begin : g_cell
                        if (k > 1) begin : g_fa
                                assign {cry_row[k][j], sum_row[k][j]} =
                                        full_add(pp[k][j], sum_row[k-1][j+1], cry_row[k-1][j]);
                        end else if (bw_corr[j+1]) begin : g_corr
                                assign {cry_row[k][j], sum_row[k][j]} =
                                        full_add(pp[k][j], pp[0][j+1], 1'b1);
                        end else begin : g_ha
                                assign {cry_row[k][j], sum_row[k][j]} =
                                        half_add(pp[k][j], pp[0][j+1]);
                        end
                end
        end

        assign low_bits[0] = pp[0][0];

        assign csa_next = {sum_row[y_w-1], cry_row[y_w-1], low_bits};

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stage register
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign pp_ready = !csa_valid || csa_ready;

        always_ff @(posedge clk) begin
                if (rst) begin
                        csa_valid <= 1'b0;
                end else if (pp_ready) begin
                        csa_valid <= pp_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (pp_valid && pp_ready) begin
                        csa_data <= csa_next;
                end
        end

        a_csa_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(csa_valid));

endmodule

// File: csam/csam_final_adder.sv
`timescale 1ns/10ps

module csam_final_adder import csam_pkg::*; (
        input  logic       clk,
        input  logic       rst,
        input  logic       csa_valid,
        output logic       csa_ready,
        input  csa_state_t csa_data,
        output logic       out_valid,
        input  logic       out_ready,
        output product_t   out_data
);

        logic [x_w-2:0] upper;          // product bits 12 to 26.
        logic           cout;
        product_t       product;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // carry-propagate adder
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        // sum[0] is already low bit 11, so the add starts at sum[1] and carry[0].
        always_comb begin
                {cout, upper[0]} = half_add(csa_data.sum[1], csa_data.carry[0]);
                for (int j = 1; j < x_w - 1; j++) begin
                        {cout, upper[j]} = full_add(csa_data.sum[j+1], csa_data.carry[j], cout);
                end
        end

        // inverting the last carry adds the 2**27 correction term.
        assign product = {~cout, upper, csa_data.low_bits};

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stage register
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        assign csa_ready = !out_valid || out_ready;

        always_ff @(posedge clk) begin
                if (rst) begin
                        out_valid <= 1'b0;
                end else if (csa_ready) begin
                        out_valid <= csa_valid;
                end
        end

        always_ff @(posedge clk) begin
                if (csa_valid && csa_ready) begin
                        out_data <= product;
                end
        end

        // the product stays put for as long as the consumer stalls.
        a_out_hold: assert property (@(posedge clk) disable iff (rst)
                out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: csam/csam_multiplier.sv
`timescale 1ns/10ps

module csam_multiplier import csam_pkg::*; (
        input  logic      clk,
        input  logic      rst,
        input  logic      in_valid,
        output logic      in_ready,
        input  operands_t in_data,
        output logic      out_valid,
        input  logic      out_ready,
        output product_t  out_data
);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stage links
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        logic       pp_valid;
        logic       pp_ready;
        pp_matrix_t pp_data;

        logic       csa_valid;
        logic       csa_ready;
        csa_state_t csa_data;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // decode, execute, result
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        csam_partial_products u_decode (
                .clk      (clk),
                .rst      (rst),
                .in_valid (in_valid),
                .in_ready (in_ready),
                .in_data  (in_data),
                .pp_valid (pp_valid),
                .pp_ready (pp_ready),
                .pp_data  (pp_data)
        );

        csam_array u_execute (
                .clk       (clk),
                .rst       (rst),
                .pp_valid  (pp_valid),
                .pp_ready  (pp_ready),
                .pp_data   (pp_data),
                .csa_valid (csa_valid),
                .csa_ready (csa_ready),
                .csa_data  (csa_data)
        );

        // ready runs back through all three stages in one cycle.
        csam_final_adder u_result (
                .clk       (clk),
                .rst       (rst),
                .csa_valid (csa_valid),
                .csa_ready (csa_ready),
                .csa_data  (csa_data),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out_data  (out_data)
        );

endmodule

// File: verification/csam_checker.sv
`timescale 1ns/10ps

module csam_checker import csam_pkg::*; (
        input  logic      clk,
        input  logic      rst,
        input  logic      in_valid,
        input  logic      in_ready,
        input  operands_t in_data,
        input  product_t  exp_data,     // product listed in the vector file.
        input  logic      out_valid,
        input  logic      out_ready,
        input  product_t  out_data,
        output int        pass_count,
        output int        fail_count,
        output int        other_errors,
        output int        max_in_flight
);

        operands_t op_q [$];
        product_t  exp_q [$];
        operands_t op;
        product_t  file_exp;
        product_t  held;
        logic      stalled;
        logic      reset_seen;
        int        n_tests;

        initial begin
                pass_count = 0;
                fail_count = 0;
                other_errors = 0;
                max_in_flight = 0;
                n_tests = 0;
                stalled = 1'b0;
                reset_seen = 1'b0;
                held = '0;
        end

        // one line per finished test, against the file value and the signed rule.
        task automatic compare_product(input operands_t ab, input product_t from_file,
                                       input product_t actual);
                product_t from_rule;
                from_rule = $signed(ab.x) * $signed(ab.y);
                n_tests++;
                if (actual !== from_file || actual !== from_rule) begin
                        fail_count++;
                        $display("error: test %0d out_data expected %h (x*y %h) actual %h",
                                 n_tests, from_file, from_rule, actual);
                end else begin
                        pass_count++;
                        $display("test %0d ok: x=%h y=%h product=%h",
                                 n_tests, ab.x, ab.y, actual);
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // port monitor
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        always @(posedge clk) begin
                if (rst) begin
                        // out_valid is unknown until the first reset edge clears it.
                        if (reset_seen && out_valid !== 1'b0) begin
                                other_errors++;
                                $display("out_valid was not low during reset");
                        end
                        reset_seen = 1'b1;
                        stalled = 1'b0;
                end else begin
                        if (stalled && (out_valid !== 1'b1 || out_data !== held)) begin
                                other_errors++;
                                $display("error: out_data held %h in a stall but shows %h",
                                         held, out_data);
                        end
                        // with the output free, every stage must accept.
                        if (out_ready && in_valid && !in_ready) begin
                                other_errors++;
                                $display("in_ready was low although out_ready was high");
                        end
                        if (out_valid && op_q.size() == 0) begin
                                other_errors++;
                                $display("out_valid was high with no operand pair waiting");
                        end else if (out_valid && out_ready) begin
                                op = op_q.pop_front();
                                file_exp = exp_q.pop_front();
                                compare_product(op, file_exp, out_data);
                        end
                        if (in_valid && in_ready) begin
                                op_q.push_back(in_data);
                                exp_q.push_back(exp_data);
                        end
                        if (op_q.size() > max_in_flight) begin
                                max_in_flight = op_q.size();
                        end
                        stalled = out_valid && !out_ready;
                        held = out_data;
                end
        end

endmodule

// File: verification/csam_tb.sv
`timescale 1ns/10ps

module csam_tb import csam_pkg::*; ();

        localparam int max_vec = 64;

        logic           clk;
        logic           rst;
        logic           in_valid;
        logic           in_ready;
        operands_t      in_data;
        product_t       exp_data;
        logic           out_valid;
        logic           out_ready;
        product_t       out_data;

        logic [p_w-1:0] vec_mem [0:3*max_vec-1];        // x, y, product per test.
        int             n_vec;
        int             limit;
        int             cycles;
        int             tb_errors;
        int             pass_count;
        int             fail_count;
        int             other_errors;
        int             max_in_flight;
        int             i;
        integer         seed;
        logic [31:0]    draw;
        logic [1:0]     idle_draw;
        logic           stalls;

        csam_multiplier DUT (
                .clk       (clk),
                .rst       (rst),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .in_data   (in_data),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .out_data  (out_data)
        );

        csam_checker u_checker (
                .clk           (clk),
                .rst           (rst),
                .in_valid      (in_valid),
                .in_ready      (in_ready),
                .in_data       (in_data),
                .exp_data      (exp_data),
                .out_valid     (out_valid),
                .out_ready     (out_ready),
                .out_data      (out_data),
                .pass_count    (pass_count),
                .fail_count    (fail_count),
                .other_errors  (other_errors),
                .max_in_flight (max_in_flight)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stimulus
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        // holds one vector on the input until the DUT takes it.
        task automatic send_vector(input int idx, input logic gaps);
                logic taken;
                while (gaps && idle_draw == 2'b00) begin
                        in_valid = 1'b0;
                        @(posedge clk);
                        #2;
                end
                in_data.x = vec_mem[3*idx][x_w-1:0];
                in_data.y = vec_mem[3*idx+1][y_w-1:0];
                exp_data = vec_mem[3*idx+2];
                in_valid = 1'b1;
                do begin
                        @(negedge clk);
                        taken = in_ready;
                        @(posedge clk);
                        #2;
                end while (!taken);
        endtask

        // out_ready and the idle draws change 1 ns after each edge.
        initial begin
                idle_draw = 2'b01;
                @(negedge rst);
                forever begin
                        @(posedge clk);
                        #1;
                        draw = $random(seed);
                        idle_draw = draw[5:4];
                        out_ready = stalls ? draw[0] : 1'b1;
                end
        end

        initial begin
                rst = 1'b1;
                in_valid = 1'b0;
                in_data = '0;
                exp_data = '0;
                out_ready = 1'b0;
                stalls = 1'b0;
                tb_errors = 0;
                seed = 32'h888c_5539;
                $readmemh("verification/csam_vectors.txt", vec_mem);
                n_vec = 0;
                while (n_vec < max_vec && !$isunknown(vec_mem[3*n_vec])) begin
                        n_vec++;
                end
                limit = n_vec * 20 + 100;
                repeat (10) @(posedge clk);
                #2;
                rst = 1'b0;
                out_ready = 1'b1;
                // first half back to back, second half with gaps and stalls.
                for (i = 0; i < n_vec / 2; i++) begin
                        send_vector(i, 1'b0);
                end
                stalls = 1'b1;
                for (i = n_vec / 2; i < n_vec; i++) begin
                        send_vector(i, 1'b1);
                end
                in_valid = 1'b0;
                while (pass_count + fail_count < n_vec) @(posedge clk);
                repeat (5) @(posedge clk);
                if (n_vec == 0) begin
                        tb_errors++;
                        $display("no vectors were read from the vector file");
                end
                if (max_in_flight < 3) begin
                        tb_errors++;
                        $display("fewer than three products were ever in flight");
                end
                $display("tests passed %0d, failed %0d, other errors %0d",
                         pass_count, fail_count, other_errors + tb_errors);
                if (fail_count == 0 && other_errors == 0 && tb_errors == 0)
                        $display("Simulation PASSED");
                else
                        $display("Simulation FAILED");
                $finish;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // timeout
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

        initial begin
                cycles = 0;
                @(posedge clk);
                while (cycles <= limit) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("timeout: the tests did not finish within %0d cycles", limit);
                $display("Simulation FAILED");
                $finish;
        end

endmodule

// File: verification/csam_vectors.txt
// columns: x (16 bits), y (12 bits), expected product x*y (28 bits), all hex.
// the first half streams back to back, the second half runs with gaps and stalls.
0000 000 0000000
0001 001 0000001
0003 005 000000f
7fff 7ff 3ff7801
8000 800 4000000
8000 7ff c008000
7fff 800 c000800
ffff fff 0000001
ffff 000 0000000
0000 fff 0000000
ffff 001 fffffff
0001 fff fffffff
ffff 7ff ffff801
7fff fff fff8001
8000 fff 0008000
ffff 800 0000800
8000 001 fff8000
0001 800 ffff800
1234 056 0061d78
0064 f9c fffd8f0
fc18 e0c 007a120
8001 003 ffe8003
5555 aaa e38ac72
0400 200 0080000
7fff 001 0007fff
0002 7ff 0000ffe

// File: project.f
common/csam_pkg.sv
csam/csam_partial_products.sv
csam/csam_array.sv
csam/csam_final_adder.sv
csam/csam_multiplier.sv
verification/csam_checker.sv
verification/csam_tb.sv
